// ==== design/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// instruction word and data path
`define DEC_INST_W 32
`define DEC_XLEN 64

// register file index
`define DEC_REG_IDX_W 5

// operation code widths
`define DEC_ALUOP_W 6
`define DEC_MEMOP_W 4
`define DEC_EXCOP_W 4
`define DEC_PCOP_W 3

`endif

// ==== design/decode_pkg.sv ====
`include "decode_settings.svh"

package decode_pkg;

  typedef logic [`DEC_INST_W-1:0]    inst_t;
  typedef logic [`DEC_XLEN-1:0]      imm_t;
  typedef logic [`DEC_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [2:0]                funct3_t;
  typedef logic [6:0]                funct7_t;
  typedef logic [11:0]               funct12_t;

  // major opcode groups, only for opcodes ending in 2'b11
  typedef enum logic [3:0] {
    cls_load, cls_store, cls_branch, cls_jalr, cls_jal,
    cls_op_imm, cls_op, cls_op_imm_32, cls_op_32,
    cls_auipc, cls_lui, cls_system, cls_none
  } inst_class_e;

  typedef enum logic [2:0] {
    fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_none
  } inst_fmt_e;

  typedef enum logic [`DEC_ALUOP_W-1:0] {
    alu_nop = 0,
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra, alu_sllw, alu_srlw, alu_sraw,
    alu_slt, alu_sltu,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
    alu_mul, alu_mulh, alu_mulhsu, alu_mulhu, alu_mulw,
    alu_div, alu_divu, alu_rem, alu_remu,
    alu_divw, alu_divuw, alu_remw, alu_remuw
  } alu_op_e;

  typedef enum logic [`DEC_MEMOP_W-1:0] {
    mem_none = 0,
    mem_lb, mem_lh, mem_lw, mem_ld, mem_lbu, mem_lhu, mem_lwu,
    mem_sb, mem_sh, mem_sw, mem_sd
  } mem_op_e;

  // one per class, ebreak split out of system
  typedef enum logic [`DEC_EXCOP_W-1:0] {
    exc_none = 0,
    exc_load, exc_store, exc_branch, exc_jalr, exc_jal,
    exc_op_imm, exc_op, exc_op_imm_32, exc_op_32,
    exc_auipc, exc_lui, exc_system, exc_ebreak
  } exc_op_e;

  typedef enum logic [`DEC_PCOP_W-1:0] {
    pc_inc4 = 0,
    pc_branch,
    pc_jal,
    pc_jalr,
    pc_trap
  } pc_op_e;

endpackage

// ==== design/decode_if.sv ====
`timescale 1ns/10ps
`include "decode_settings.svh"

// split fields of the word being decoded
interface decode_fields_if import decode_pkg::*; ();
  inst_class_e inst_class;
  inst_fmt_e   inst_fmt;
  funct3_t     funct3;
  funct7_t     funct7;
  funct12_t    funct12;
  inst_t       inst;

  modport src (output inst_class, inst_fmt, funct3, funct7, funct12, inst);
  modport dst (input inst_class, inst_fmt, funct3, funct7, funct12, inst);
endinterface

// decoded result ahead of the output register
interface decode_result_if import decode_pkg::*; ();
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  imm_t     imm;
  alu_op_e  alu_op;
  mem_op_e  mem_op;
  exc_op_e  exc_op;
  pc_op_e   pc_op;
  logic     trap_ecall;
  logic     trap_ebreak;
  logic     trap_mret;

  modport src (
    output rs1, rs2, rd, imm, alu_op, mem_op, exc_op, pc_op,
    output trap_ecall, trap_ebreak, trap_mret
  );
  modport dst (
    input rs1, rs2, rd, imm, alu_op, mem_op, exc_op, pc_op,
    input trap_ecall, trap_ebreak, trap_mret
  );
endinterface

// ==== design/decode_classify.sv ====
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_classify import decode_pkg::*; (
  input  inst_t        i_inst,
  decode_fields_if.src fields,
  decode_result_if.src result
);

  logic [6:0]  opcode;
  inst_class_e inst_class;
  inst_fmt_e   inst_fmt;
  logic        need_rs1;
  logic        need_rs2;
  logic        need_rd;

  assign opcode = i_inst[6:0];

  // opcode[6:2] picks the group once the low bits say 32-bit encoding
  always_comb begin
    inst_class = cls_none;
    if (opcode[1:0] == 2'b11) begin
      case (opcode[6:2])
        5'b00000: inst_class = cls_load;
        5'b01000: inst_class = cls_store;
        5'b11000: inst_class = cls_branch;
        5'b11001: inst_class = cls_jalr;
        5'b11011: inst_class = cls_jal;
        5'b00100: inst_class = cls_op_imm;
        5'b01100: inst_class = cls_op;
        5'b00110: inst_class = cls_op_imm_32;
        5'b01110: inst_class = cls_op_32;
        5'b00101: inst_class = cls_auipc;
        5'b01101: inst_class = cls_lui;
        5'b11100: inst_class = cls_system;
        default:  inst_class = cls_none;
      endcase
    end
  end

  always_comb begin
    case (inst_class)
      cls_op, cls_op_32: inst_fmt = fmt_r;
      cls_load, cls_op_imm, cls_op_imm_32, cls_jalr, cls_system: inst_fmt = fmt_i;
      cls_store:          inst_fmt = fmt_s;
      cls_branch:         inst_fmt = fmt_b;
      cls_auipc, cls_lui: inst_fmt = fmt_u;
      cls_jal:            inst_fmt = fmt_j;
      default:            inst_fmt = fmt_none;
    endcase
  end

  // which register slots the format actually uses
  assign need_rs1 = inst_fmt inside {fmt_r, fmt_i, fmt_s, fmt_b};
  assign need_rs2 = inst_fmt inside {fmt_r, fmt_s, fmt_b};
  assign need_rd  = inst_fmt inside {fmt_r, fmt_i, fmt_u, fmt_j};

  assign fields.inst       = i_inst;
  assign fields.inst_class = inst_class;
  assign fields.inst_fmt   = inst_fmt;
  assign fields.funct3     = i_inst[14:12];
  assign fields.funct7     = i_inst[31:25];
  assign fields.funct12    = i_inst[31:20];

  assign result.rs1 = need_rs1 ? i_inst[19:15] : '0;
  assign result.rs2 = need_rs2 ? i_inst[24:20] : '0;
  assign result.rd  = need_rd  ? i_inst[11:7]  : '0;

  // an unknown opcode gets no format and touches no register
  always_comb begin
    a_none_class_no_fmt: assert final (inst_class != cls_none ||
      (inst_fmt == fmt_none && result.rs1 == '0 && result.rs2 == '0 && result.rd == '0));
  end

endmodule

// ==== design/decode_imm_gen.sv ====
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_imm_gen import decode_pkg::*; (
  decode_fields_if.dst fields,
  decode_result_if.src result
);

  inst_t inst;
  imm_t  imm_i;
  imm_t  imm_s;
  imm_t  imm_b;
  imm_t  imm_u;
  imm_t  imm_j;

  assign inst = fields.inst;

  // sign always from bit 31
  assign imm_i = {{(`DEC_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`DEC_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`DEC_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(`DEC_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`DEC_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (fields.inst_fmt)
      fmt_i:   result.imm = imm_i;
      fmt_s:   result.imm = imm_s;
      fmt_b:   result.imm = imm_b;
      fmt_u:   result.imm = imm_u;
      fmt_j:   result.imm = imm_j;
      default: result.imm = '0;
    endcase
  end

  // branch and jump targets are halfword aligned
  always_comb begin
    a_bj_even: assert final (!(fields.inst_fmt inside {fmt_b, fmt_j}) || !result.imm[0]);
  end

endmodule

// ==== design/decode_op_encode.sv ====
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_op_encode import decode_pkg::*; (
  decode_fields_if.dst fields,
  decode_result_if.src result
);

  inst_class_e cls;
  funct3_t     f3;
  funct7_t     f7;
  logic        priv;

  assign cls = fields.inst_class;
  assign f3  = fields.funct3;
  assign f7  = fields.funct7;

  // system with funct3 000 carries the trap encodings in funct12
  assign priv               = (cls == cls_system) && (f3 == 3'b000);
  assign result.trap_ecall  = priv && (fields.funct12 == 12'h000);
  assign result.trap_ebreak = priv && (fields.funct12 == 12'h001);
  assign result.trap_mret   = priv && (fields.funct12 == 12'h302);

  always_comb begin
    result.alu_op = alu_nop;
    case (cls)
      cls_load, cls_store, cls_jal, cls_jalr, cls_auipc, cls_lui: result.alu_op = alu_add;
      cls_branch: begin
        case (f3)
          3'b000:  result.alu_op = alu_beq;
          3'b001:  result.alu_op = alu_bne;
          3'b100:  result.alu_op = alu_blt;
          3'b101:  result.alu_op = alu_bge;
          3'b110:  result.alu_op = alu_bltu;
          3'b111:  result.alu_op = alu_bgeu;
          default: result.alu_op = alu_nop;
        endcase
      end
      cls_op_imm: begin
        case (f3)
          3'b000: result.alu_op = alu_add;
          3'b010: result.alu_op = alu_slt;
          3'b011: result.alu_op = alu_sltu;
          3'b100: result.alu_op = alu_xor;
          3'b110: result.alu_op = alu_or;
          3'b111: result.alu_op = alu_and;
          // shamt is six bits on rv64, funct7[0] belongs to it
          3'b001: if (f7[6:1] == 6'b000000) result.alu_op = alu_sll;
          3'b101: begin
            if (f7[6:1] == 6'b000000) result.alu_op = alu_srl;
            else if (f7[6:1] == 6'b010000) result.alu_op = alu_sra;
          end
          default: result.alu_op = alu_nop;
        endcase
      end
      cls_op_imm_32: begin
        if (f3 == 3'b000) result.alu_op = alu_add;
        else if (f3 == 3'b001 && f7 == 7'b0000000) result.alu_op = alu_sllw;
        else if (f3 == 3'b101 && f7 == 7'b0000000) result.alu_op = alu_srlw;
        else if (f3 == 3'b101 && f7 == 7'b0100000) result.alu_op = alu_sraw;
      end
      cls_op: begin
        if (f7 == 7'b0000001) begin
          case (f3)
            3'b000: result.alu_op = alu_mul;
            3'b001: result.alu_op = alu_mulh;
            3'b010: result.alu_op = alu_mulhsu;
            3'b011: result.alu_op = alu_mulhu;
            3'b100: result.alu_op = alu_div;
            3'b101: result.alu_op = alu_divu;
            3'b110: result.alu_op = alu_rem;
            3'b111: result.alu_op = alu_remu;
          endcase
        end else if (f7 == 7'b0000000) begin
          case (f3)
            3'b000: result.alu_op = alu_add;
            3'b001: result.alu_op = alu_sll;
            3'b010: result.alu_op = alu_slt;
            3'b011: result.alu_op = alu_sltu;
            3'b100: result.alu_op = alu_xor;
            3'b101: result.alu_op = alu_srl;
            3'b110: result.alu_op = alu_or;
            3'b111: result.alu_op = alu_and;
          endcase
        end else if (f7 == 7'b0100000) begin
          if (f3 == 3'b000) result.alu_op = alu_sub;
          else if (f3 == 3'b101) result.alu_op = alu_sra;
        end
      end
      cls_op_32: begin
        if (f7 == 7'b0000001) begin
          case (f3)
            3'b000:  result.alu_op = alu_mulw;
            3'b100:  result.alu_op = alu_divw;
            3'b101:  result.alu_op = alu_divuw;
            3'b110:  result.alu_op = alu_remw;
            3'b111:  result.alu_op = alu_remuw;
            default: result.alu_op = alu_nop;
          endcase
        end else if (f7 == 7'b0000000) begin
          if (f3 == 3'b000) result.alu_op = alu_add;
          else if (f3 == 3'b001) result.alu_op = alu_sllw;
          else if (f3 == 3'b101) result.alu_op = alu_srlw;
        end else if (f7 == 7'b0100000) begin
          if (f3 == 3'b000) result.alu_op = alu_sub;
          else if (f3 == 3'b101) result.alu_op = alu_sraw;
        end
      end
      default: result.alu_op = alu_nop;
    endcase
  end

  always_comb begin
    result.mem_op = mem_none;
    if (cls == cls_load) begin
      case (f3)
        3'b000:  result.mem_op = mem_lb;
        3'b001:  result.mem_op = mem_lh;
        3'b010:  result.mem_op = mem_lw;
        3'b011:  result.mem_op = mem_ld;
        3'b100:  result.mem_op = mem_lbu;
        3'b101:  result.mem_op = mem_lhu;
        3'b110:  result.mem_op = mem_lwu;
        default: result.mem_op = mem_none;
      endcase
    end else if (cls == cls_store) begin
      case (f3)
        3'b000:  result.mem_op = mem_sb;
        3'b001:  result.mem_op = mem_sh;
        3'b010:  result.mem_op = mem_sw;
        3'b011:  result.mem_op = mem_sd;
        default: result.mem_op = mem_none;
      endcase
    end
  end

  always_comb begin
    case (cls)
      cls_load:      result.exc_op = exc_load;
      cls_store:     result.exc_op = exc_store;
      cls_branch:    result.exc_op = exc_branch;
      cls_jalr:      result.exc_op = exc_jalr;
      cls_jal:       result.exc_op = exc_jal;
      cls_op_imm:    result.exc_op = exc_op_imm;
      cls_op:        result.exc_op = exc_op;
      cls_op_imm_32: result.exc_op = exc_op_imm_32;
      cls_op_32:     result.exc_op = exc_op_32;
      cls_auipc:     result.exc_op = exc_auipc;
      cls_lui:       result.exc_op = exc_lui;
      cls_system:    result.exc_op = result.trap_ebreak ? exc_ebreak : exc_system;
      default:       result.exc_op = exc_none;
    endcase
  end

  // priority order, ebreak stays on inc4
  always_comb begin
    if (cls == cls_branch) result.pc_op = pc_branch;
    else if (cls == cls_jal) result.pc_op = pc_jal;
    else if (cls == cls_jalr) result.pc_op = pc_jalr;
    else if (result.trap_ecall || result.trap_mret) result.pc_op = pc_trap;
    else result.pc_op = pc_inc4;
  end

endmodule

// ==== design/decode_out_reg.sv ====
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_out_reg import decode_pkg::*; (
  input  logic         i_clk,
  input  logic         i_arst_n,
  input  logic         i_valid,
  output logic         o_ready,
  input  logic         i_ready,
  output logic         o_valid,
  decode_result_if.dst d,
  output reg_idx_t     o_rs1,
  output reg_idx_t     o_rs2,
  output reg_idx_t     o_rd,
  output imm_t         o_imm,
  output alu_op_e      o_alu_op,
  output mem_op_e      o_mem_op,
  output exc_op_e      o_exc_op,
  output pc_op_e       o_pc_op,
  output logic         o_trap_ecall,
  output logic         o_trap_ebreak,
  output logic         o_trap_mret
);

  logic load;

  // free when empty or draining this edge
  assign o_ready = !o_valid || i_ready;
  assign load    = i_valid && o_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (load) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      o_rs1         <= d.rs1;
      o_rs2         <= d.rs2;
      o_rd          <= d.rd;
      o_imm         <= d.imm;
      o_alu_op      <= d.alu_op;
      o_mem_op      <= d.mem_op;
      o_exc_op      <= d.exc_op;
      o_pc_op       <= d.pc_op;
      o_trap_ecall  <= d.trap_ecall;
      o_trap_ebreak <= d.trap_ebreak;
      o_trap_mret   <= d.trap_mret;
    end
  end

  a_hold_stalled: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_valid && !i_ready) |=> o_valid && $stable({o_rs1, o_rs2, o_rd, o_imm, o_alu_op,
      o_mem_op, o_exc_op, o_pc_op, o_trap_ecall, o_trap_ebreak, o_trap_mret}))
    else $error("decoded result changed while stalled");

endmodule

// ==== design/decode_top.sv ====
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_top import decode_pkg::*; (
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  inst_t    i_inst,
  input  logic     i_valid,
  output logic     o_ready,
  input  logic     i_ready,
  output logic     o_valid,
  output reg_idx_t o_rs1,
  output reg_idx_t o_rs2,
  output reg_idx_t o_rd,
  output imm_t     o_imm,
  output alu_op_e  o_alu_op,
  output mem_op_e  o_mem_op,
  output exc_op_e  o_exc_op,
  output pc_op_e   o_pc_op,
  output logic     o_trap_ecall,
  output logic     o_trap_ebreak,
  output logic     o_trap_mret
);

  decode_fields_if fields_if ();
  decode_result_if result_if ();

  // combinational decode
  decode_classify decode_classify_i (
    .i_inst (i_inst),
    .fields (fields_if.src),
    .result (result_if.src)
  );

  decode_imm_gen decode_imm_gen_i (
    .fields (fields_if.dst),
    .result (result_if.src)
  );

  decode_op_encode decode_op_encode_i (
    .fields (fields_if.dst),
    .result (result_if.src)
  );

  // one-entry pipeline register
  decode_out_reg decode_out_reg_i (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_ready       (i_ready),
    .o_valid       (o_valid),
    .d             (result_if.dst),
    .o_rs1         (o_rs1),
    .o_rs2         (o_rs2),
    .o_rd          (o_rd),
    .o_imm         (o_imm),
    .o_alu_op      (o_alu_op),
    .o_mem_op      (o_mem_op),
    .o_exc_op      (o_exc_op),
    .o_pc_op       (o_pc_op),
    .o_trap_ecall  (o_trap_ecall),
    .o_trap_ebreak (o_trap_ebreak),
    .o_trap_mret   (o_trap_mret)
  );

endmodule

// ==== tb/decode_tb.sv ====
`timescale 1ns/10ps
`include "decode_settings.svh"

module decode_tb;

  localparam int MAX_TESTS = 64;
  localparam int N_FIELDS  = 11;

  logic                      clk;
  logic                      arst_n;
  logic [`DEC_INST_W-1:0]    inst;
  logic                      in_valid;
  logic                      in_ready;
  logic                      out_ready;
  logic                      out_valid;
  logic [`DEC_REG_IDX_W-1:0] rs1;
  logic [`DEC_REG_IDX_W-1:0] rs2;
  logic [`DEC_REG_IDX_W-1:0] rd;
  logic [`DEC_XLEN-1:0]      imm;
  logic [`DEC_ALUOP_W-1:0]   alu_op;
  logic [`DEC_MEMOP_W-1:0]   mem_op;
  logic [`DEC_EXCOP_W-1:0]   exc_op;
  logic [`DEC_PCOP_W-1:0]    pc_op;
  logic                      trap_ecall;
  logic                      trap_ebreak;
  logic                      trap_mret;

  // trace contents, expected fields in trace column order
  logic [127:0]           t_name [MAX_TESTS];
  logic [`DEC_INST_W-1:0] t_inst [MAX_TESTS];
  logic [63:0]            t_exp  [MAX_TESTS][N_FIELDS];
  string field_name [N_FIELDS] = '{"rs1", "rs2", "rd", "imm", "alu_op", "mem_op",
                                   "exc_op", "pc_op", "trap_ecall", "trap_ebreak", "trap_mret"};

  int          n_tests;
  int          sent;
  int          pending [$];
  logic [15:0] lfsr;
  logic        trace_loaded;

  decode_top decode_top_i (
    .i_clk         (clk),
    .i_arst_n      (arst_n),
    .i_inst        (inst),
    .i_valid       (in_valid),
    .o_ready       (out_ready),
    .i_ready       (in_ready),
    .o_valid       (out_valid),
    .o_rs1         (rs1),
    .o_rs2         (rs2),
    .o_rd          (rd),
    .o_imm         (imm),
    .o_alu_op      (alu_op),
    .o_mem_op      (mem_op),
    .o_exc_op      (exc_op),
    .o_pc_op       (pc_op),
    .o_trap_ecall  (trap_ecall),
    .o_trap_ebreak (trap_ebreak),
    .o_trap_mret   (trap_mret)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) return (s >> 1) ^ 16'hb400;
    return s >> 1;
  endfunction

  task take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b = lfsr[0];
  endtask

  task abort_run(input string why);
    $display("%0s", why);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  task load_trace();
    int fd;
    int cnt;
    logic [8*256-1:0] line;
    fd = $fopen("tb/decode_trace.txt", "r");
    if (fd == 0) abort_run("cannot open the trace file tb/decode_trace.txt");
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      line = '0;
      if ($fgets(line, fd) > 0) begin
        // comment and blank lines never match all columns
        cnt = $sscanf(line, "%s %h %d %d %d %h %d %d %d %d %d %d %d",
          t_name[n_tests], t_inst[n_tests], t_exp[n_tests][0], t_exp[n_tests][1],
          t_exp[n_tests][2], t_exp[n_tests][3], t_exp[n_tests][4], t_exp[n_tests][5],
          t_exp[n_tests][6], t_exp[n_tests][7], t_exp[n_tests][8], t_exp[n_tests][9],
          t_exp[n_tests][10]);
        if (cnt == 13) n_tests++;
      end
    end
    $fclose(fd);
    if (n_tests == 0) abort_run("the trace file holds no test lines");
  endtask

  task check_result(input int idx);
    logic [63:0] act [N_FIELDS];
    act[0]  = rs1;
    act[1]  = rs2;
    act[2]  = rd;
    act[3]  = imm;
    act[4]  = alu_op;
    act[5]  = mem_op;
    act[6]  = exc_op;
    act[7]  = pc_op;
    act[8]  = trap_ecall;
    act[9]  = trap_ebreak;
    act[10] = trap_mret;
    for (int k = 0; k < N_FIELDS; k++) begin
      assert (act[k] === t_exp[idx][k]) else begin
        $display("ERR %0s %0s expected %0h actual %0h",
          t_name[idx], field_name[k], t_exp[idx][k], act[k]);
        $display("Checks failed");
        $fatal(1, "decoded field mismatch");
      end
    end
  endtask

  // one entry at most, so valid follows the queue and ready follows valid and back-pressure
  task check_handshake();
    logic exp_valid;
    logic exp_ready;
    exp_valid = pending.size() > 0;
    exp_ready = !exp_valid || in_ready;
    assert (out_valid === exp_valid && out_ready === exp_ready) else begin
      $display("ERR handshake expected valid %0b ready %0b actual valid %0b ready %0b",
        exp_valid, exp_ready, out_valid, out_ready);
      $display("Checks failed");
      $fatal(1, "handshake mismatch");
    end
  endtask

  initial begin
    logic vbit;
    logic rbit;
    arst_n       = 1'b0;
    inst         = '0;
    in_valid     = 1'b0;
    in_ready     = 1'b0;
    lfsr         = 16'd3768;
    n_tests      = 0;
    sent         = 0;
    trace_loaded = 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    while (sent < n_tests || pending.size() > 0) begin
      // handshakes seen mid cycle happen on the next rising edge
      @(negedge clk);
      check_handshake();
      if (out_valid && in_ready) begin
        if (pending.size() == 0) begin
          abort_run("a result came out with no accepted instruction waiting");
        end else begin
          check_result(pending.pop_front());
        end
      end
      if (in_valid && out_ready) begin
        pending.push_back(sent);
        sent++;
      end
      @(posedge clk);
      take_bit(vbit);
      take_bit(rbit);
      in_ready <= rbit;
      if (sent < n_tests) begin
        inst     <= t_inst[sent];
        in_valid <= vbit;
      end else begin
        in_valid <= 1'b0;
      end
    end
    @(negedge clk);
    if (!out_valid) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("a result is still pending after the last instruction left");
      $display("Checks failed");
      $fatal(1, "extra result");
    end
  end

  // 20 cycles per trace line on top of reset
  initial begin
    wait (trace_loaded);
    repeat (n_tests * 20 + 12) @(posedge clk);
    abort_run("watchdog expired, results stopped arriving");
  end

endmodule

// ==== tb/decode_trace.txt ====
# name inst rs1 rs2 rd imm alu mem exc pc ecall ebreak mret
# inst and imm in hex, all other columns in decimal
add        002081b3 1  2  3  0000000000000000 1  0  7  0 0 0 0
sub        407302b3 6  7  5  0000000000000000 2  0  7  0 0 0 0
xor        00c5c533 11 12 10 0000000000000000 3  0  7  0 0 0 0
sra        403150b3 2  3  1  0000000000000000 8  0  7  0 0 0 0
op_bad_f7  202081b3 1  2  3  0000000000000000 0  0  7  0 0 0 0
addw       002081bb 1  2  3  0000000000000000 1  0  9  0 0 0 0
subw       402081bb 1  2  3  0000000000000000 2  0  9  0 0 0 0
sraw       4020d1bb 1  2  3  0000000000000000 11 0  9  0 0 0 0
mul        022081b3 1  2  3  0000000000000000 20 0  7  0 0 0 0
div        0220c1b3 1  2  3  0000000000000000 25 0  7  0 0 0 0
mulw       022081bb 1  2  3  0000000000000000 24 0  9  0 0 0 0
divuw      0220d1bb 1  2  3  0000000000000000 30 0  9  0 0 0 0
remw       0220e1bb 1  2  3  0000000000000000 31 0  9  0 0 0 0
addi_neg   fff10093 2  0  1  ffffffffffffffff 1  0  6  0 0 0 0
andi       07f37293 6  0  5  000000000000007f 5  0  6  0 0 0 0
slli_63    03f11093 2  0  1  000000000000003f 6  0  6  0 0 0 0
srai_33    42115093 2  0  1  0000000000000421 8  0  6  0 0 0 0
slti_min   80012093 2  0  1  fffffffffffff800 12 0  6  0 0 0 0
addiw      0011009b 2  0  1  0000000000000001 1  0  8  0 0 0 0
sraiw      4031509b 2  0  1  0000000000000403 11 0  8  0 0 0 0
ld_neg     ff813083 2  0  1  fffffffffffffff8 1  4  1  0 0 0 0
lbu        01034283 6  0  5  0000000000000010 1  5  1  0 0 0 0
sd         0020b423 1  2  0  0000000000000008 1  11 2  0 0 0 0
sw_neg     fe532e23 6  5  0  fffffffffffffffc 1  10 2  0 0 0 0
beq        00208863 1  2  0  0000000000000010 14 0  3  1 0 0 0
bne_neg    fe419ce3 3  4  0  fffffffffffffff8 15 0  3  1 0 0 0
bgeu       0062f0e3 5  6  0  0000000000000800 19 0  3  1 0 0 0
blt_min    8020c063 1  2  0  fffffffffffff000 16 0  3  1 0 0 0
jal        001000ef 0  0  1  0000000000000800 1  0  5  2 0 0 0
jal_neg    fffff06f 0  0  0  fffffffffffffffe 1  0  5  2 0 0 0
jalr       00c280e7 5  0  1  000000000000000c 1  0  4  3 0 0 0
lui        123452b7 0  0  5  0000000012345000 1  0  11 0 0 0 0
lui_neg    800000b7 0  0  1  ffffffff80000000 1  0  11 0 0 0 0
auipc_neg  fffff197 0  0  3  fffffffffffff000 1  0  10 0 0 0 0
ecall      00000073 0  0  0  0000000000000000 0  0  12 4 1 0 0
ebreak     00100073 0  0  0  0000000000000001 0  0  13 0 0 1 0
mret       30200073 0  0  0  0000000000000302 0  0  12 4 0 0 1
csrrw      300110f3 2  0  1  0000000000000300 0  0  12 0 0 0 0
short_enc  002081b1 0  0  0  0000000000000000 0  0  0  0 0 0 0
bad_opcode 002081ff 0  0  0  0000000000000000 0  0  0  0 0 0 0

// ==== all.f ====
+incdir+design
design/decode_pkg.sv
design/decode_if.sv
design/decode_classify.sv
design/decode_imm_gen.sv
design/decode_op_encode.sv
design/decode_out_reg.sv
design/decode_top.sv
tb/decode_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - design
    files:
      - design/decode_pkg.sv
      - design/decode_if.sv
      - design/decode_classify.sv
      - design/decode_imm_gen.sv
      - design/decode_op_encode.sv
      - design/decode_out_reg.sv
      - design/decode_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/decode_tb.sv
